//--- hdl/pkt_pkg.sv
`default_nettype none

package pkt_pkg;

  // one buffered input word
  // nbytes counts valid bytes from the low end, 1 to 8
  typedef struct packed {
    logic [63:0] data;
    logic [3:0]  nbytes;
    logic        last;
  } pkt_word_t;

  // record pushed once per completed packet
  typedef struct packed {
    logic [15:0] byte_len;
    logic [15:0] word_cnt;
  } pkt_len_t;

  // header word placed in front of each packet
  // reserved is sent as zero
  typedef struct packed {
    logic [15:0] byte_len;
    logic [15:0] word_cnt;
    logic [15:0] seq;
    logic [15:0] reserved;
  } pkt_hdr_t;

  // egress payload read as raw data or as a header
  // is_hdr in pkt_out_t selects the view
  typedef union packed {
    logic [63:0] raw;
    pkt_hdr_t    hdr;
  } pkt_body_u;

  // one egress word
  typedef struct packed {
    logic      is_hdr;
    pkt_body_u body;
    logic [3:0] nbytes;
    logic      last;
  } pkt_out_t;

  // record widths that size the two FIFO instances
  localparam int PKT_WORD_W = $bits(pkt_word_t);
  localparam int PKT_LEN_W  = $bits(pkt_len_t);

endpackage

`default_nettype wire

//--- hdl/srl_fifo_d.sv
`timescale 1ns/1ps
`default_nettype none

module srl_fifo_d #(
  parameter int width   = 64,
  parameter int l2depth = 5
) (
  input  wire               CLK,
  input  wire               arst_n,
  input  wire               clr,
  input  wire               enq,
  input  wire               deq,
  output logic              full_n,
  output logic              empty_n,
  input  wire [width-1:0]   d_in,
  output logic [width-1:0]  d_out
);

  localparam int depth = 2 ** l2depth;

  // shift register storage with the newest word in entry 0
  logic [width-1:0]   srl_q [depth];
  // one-word output stage behind the shift register
  logic [width-1:0]   dreg_q;
  // number of words held in the shift register
  logic [l2depth-1:0] pos_q;
  logic               sempty_q;
  logic               sfull_q;
  logic               dempty_q;
  // move head of shift register into the output stage
  logic               sdx;
  logic [l2depth-1:0] head_idx;

  // the oldest word sits just below pos
  assign head_idx = pos_q - 1'b1;

  // refill when output stage is empty, or is being popped in this cycle
  assign sdx = !sempty_q && (dempty_q || deq);

  // every enq pushes all entries one place up
  always_ff @(posedge CLK) begin
    if (enq) begin
      srl_q[0] <= d_in;
      for (int i = 1; i < depth; i++) begin
        srl_q[i] <= srl_q[i-1];
      end
    end
  end

  // output stage payload
  always_ff @(posedge CLK) begin
    if (sdx) begin
      dreg_q <= srl_q[head_idx];
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      pos_q    <= '0;
      sempty_q <= 1'b1;
      sfull_q  <= 1'b0;
      dempty_q <= 1'b1;
    end else if (clr) begin
      pos_q    <= '0;
      sempty_q <= 1'b1;
      sfull_q  <= 1'b0;
      dempty_q <= 1'b1;
    end else begin
      // enq and sdx together leave the count unchanged
      if (enq && !sdx) begin
        pos_q <= pos_q + 1'b1;
      end else if (!enq && sdx) begin
        pos_q <= pos_q - 1'b1;
      end
      // flags are computed from the next count
      sempty_q <= (pos_q == 0 && !enq) || (pos_q == 1 && sdx && !enq);
      sfull_q  <= (pos_q == depth - 1 && !sdx) ||
                  (pos_q == depth - 2 && enq && !sdx);
      // output stage goes empty only on a pop with nothing behind it
      if (sdx) begin
        dempty_q <= 1'b0;
      end else if (deq) begin
        dempty_q <= 1'b1;
      end
    end
  end

  assign full_n  = !sfull_q;
  assign empty_n = !dempty_q;
  assign d_out   = dreg_q;

  // writer and reader must honour the level flags
  a_enq_not_full: assert property (
    @(posedge CLK) disable iff (!arst_n) enq |-> full_n
  ) else $error("srl_fifo_d: enq while full");

  a_deq_not_empty: assert property (
    @(posedge CLK) disable iff (!arst_n) deq |-> empty_n
  ) else $error("srl_fifo_d: deq while empty");

endmodule

`default_nettype wire

//--- hdl/pkt_ingress.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_ingress (
  input  wire                CLK,
  input  wire                arst_n,
  input  wire                clr,
  // upstream word stream
  input  wire                in_enq,
  input  wire pkt_pkg::pkt_word_t in_word,
  output logic               in_full_n,
  // space in the two FIFOs
  input  wire                data_full_n,
  input  wire                len_full_n,
  // toward data FIFO
  output logic               data_enq,
  output pkt_pkg::pkt_word_t data_word,
  // toward length FIFO
  output logic               len_enq,
  output pkt_pkg::pkt_len_t  len_rec
);

  // running totals of the packet in progress
  logic [15:0] byte_sum_q;
  logic [15:0] word_cnt_q;
  // totals including the word on the input now
  logic [15:0] byte_sum_nxt;
  logic [15:0] word_cnt_nxt;

  assign byte_sum_nxt = byte_sum_q + 16'(in_word.nbytes);
  assign word_cnt_nxt = word_cnt_q + 16'd1;

  // accept only while both FIFOs have room
  // the length FIFO can fill first on a run of short packets
  assign in_full_n = data_full_n & len_full_n;

  // every accepted word goes to the data FIFO unchanged
  assign data_enq  = in_enq;
  assign data_word = in_word;

  // last word closes the packet, record goes out in the same cycle
  assign len_enq          = in_enq & in_word.last;
  assign len_rec.byte_len = byte_sum_nxt;
  assign len_rec.word_cnt = word_cnt_nxt;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      byte_sum_q <= '0;
      word_cnt_q <= '0;
    end else if (clr) begin
      // partial packet is dropped
      byte_sum_q <= '0;
      word_cnt_q <= '0;
    end else if (in_enq) begin
      if (in_word.last) begin
        byte_sum_q <= '0;
        word_cnt_q <= '0;
      end else begin
        byte_sum_q <= byte_sum_nxt;
        word_cnt_q <= word_cnt_nxt;
      end
    end
  end

  // a zero or oversize byte count would corrupt the header length
  a_nbytes_range: assert property (
    @(posedge CLK) disable iff (!arst_n)
      in_enq |-> (in_word.nbytes inside {[4'd1:4'd8]})
  ) else $error("pkt_ingress: nbytes %0d out of range", in_word.nbytes);

endmodule

`default_nettype wire

//--- hdl/pkt_egress.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_egress (
  input  wire                CLK,
  input  wire                arst_n,
  input  wire                clr,
  // length FIFO read side
  input  wire                len_empty_n,
  input  wire pkt_pkg::pkt_len_t len_rec_out,
  output logic               len_deq,
  // data FIFO read side
  input  wire                data_empty_n,
  input  wire pkt_pkg::pkt_word_t data_word_out,
  output logic               data_deq,
  // downstream sink
  output logic               out_empty_n,
  output pkt_pkg::pkt_out_t  out_word,
  input  wire                out_deq
);

  // idle waits for a length record
  // hdr holds the header while the first data word is still to come
  // body moves the remaining data words
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_HDR,
    ST_BODY
  } state_t;

  state_t             state_q;
  state_t             state_d;
  logic               out_valid_q;
  pkt_pkg::pkt_out_t  out_q;
  pkt_pkg::pkt_out_t  out_d;
  pkt_pkg::pkt_hdr_t  hdr;
  // packet sequence number for the next header
  logic [15:0]        seq_q;
  logic               can_load;
  logic               hdr_ld;
  logic               body_ld;

  // output register is free, or its word leaves this cycle
  assign can_load = !out_valid_q || out_deq;

  assign hdr_ld  = (state_q == ST_IDLE) && len_empty_n && can_load;
  // all words of the packet are already queued once its record is visible
  assign body_ld = (state_q != ST_IDLE) && can_load;

  assign len_deq  = hdr_ld;
  assign data_deq = body_ld;

  always_comb begin
    hdr.byte_len = len_rec_out.byte_len;
    hdr.word_cnt = len_rec_out.word_cnt;
    hdr.seq      = seq_q;
    hdr.reserved = '0;
  end

  always_comb begin
    out_d   = out_q;
    state_d = state_q;
    if (hdr_ld) begin
      out_d.is_hdr   = 1'b1;
      out_d.body.hdr = hdr;
      out_d.nbytes   = 4'd8;
      out_d.last     = 1'b0;
      state_d        = ST_HDR;
    end else if (body_ld) begin
      out_d.is_hdr   = 1'b0;
      out_d.body.raw = data_word_out.data;
      out_d.nbytes   = data_word_out.nbytes;
      out_d.last     = data_word_out.last;
      // one-word packets go straight from hdr back to idle
      state_d        = data_word_out.last ? ST_IDLE : ST_BODY;
    end
  end

  // output payload register
  always_ff @(posedge CLK) begin
    if (hdr_ld || body_ld) begin
      out_q <= out_d;
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state_q     <= ST_IDLE;
      out_valid_q <= 1'b0;
      seq_q       <= '0;
    end else if (clr) begin
      // seq restarts with the next packet
      state_q     <= ST_IDLE;
      out_valid_q <= 1'b0;
      seq_q       <= '0;
    end else begin
      state_q <= state_d;
      if (hdr_ld || body_ld) begin
        out_valid_q <= 1'b1;
      end else if (out_deq) begin
        out_valid_q <= 1'b0;
      end
      if (hdr_ld) begin
        seq_q <= seq_q + 16'd1;
      end
    end
  end

  assign out_empty_n = out_valid_q;
  assign out_word    = out_q;

  // a stalled sink sees the same word on the next cycle
  a_out_hold: assert property (
    @(posedge CLK) disable iff (!arst_n || clr)
      (out_empty_n && !out_deq) |=> (out_empty_n && $stable(out_word))
  ) else $error("pkt_egress: out_word changed under stall");

  // ingress queues the data before the record, so data must be there
  a_body_data: assert property (
    @(posedge CLK) disable iff (!arst_n || clr)
      body_ld |-> data_empty_n
  ) else $error("pkt_egress: body load with data FIFO empty");

endmodule

`default_nettype wire

//--- hdl/pkt_len_prepend.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_len_prepend #(
  parameter int data_l2depth = 5,
  parameter int len_l2depth  = 3
) (
  input  wire                CLK,
  input  wire                arst_n,
  input  wire                clr,
  input  wire                in_enq,
  input  wire pkt_pkg::pkt_word_t in_word,
  output logic               in_full_n,
  output logic               out_empty_n,
  input  wire                out_deq,
  output pkt_pkg::pkt_out_t  out_word
);

  // ingress side of the FIFO pair
  logic               data_enq;
  logic               data_full_n;
  pkt_pkg::pkt_word_t data_word;
  logic               len_enq;
  logic               len_full_n;
  pkt_pkg::pkt_len_t  len_rec;
  // egress side of the FIFO pair
  logic               data_deq;
  logic               data_empty_n;
  pkt_pkg::pkt_word_t data_word_out;
  logic               len_deq;
  logic               len_empty_n;
  pkt_pkg::pkt_len_t  len_rec_out;

  pkt_ingress u_ingress (
    .CLK         (CLK),
    .arst_n      (arst_n),
    .clr         (clr),
    .in_enq      (in_enq),
    .in_word     (in_word),
    .in_full_n   (in_full_n),
    .data_full_n (data_full_n),
    .len_full_n  (len_full_n),
    .data_enq    (data_enq),
    .data_word   (data_word),
    .len_enq     (len_enq),
    .len_rec     (len_rec)
  );

  // whole packets wait here until egress reaches them
  srl_fifo_d #(
    .width   (pkt_pkg::PKT_WORD_W),
    .l2depth (data_l2depth)
  ) u_data_fifo (
    .CLK     (CLK),
    .arst_n  (arst_n),
    .clr     (clr),
    .enq     (data_enq),
    .deq     (data_deq),
    .full_n  (data_full_n),
    .empty_n (data_empty_n),
    .d_in    (data_word),
    .d_out   (data_word_out)
  );

  // one record per completed packet
  srl_fifo_d #(
    .width   (pkt_pkg::PKT_LEN_W),
    .l2depth (len_l2depth)
  ) u_len_fifo (
    .CLK     (CLK),
    .arst_n  (arst_n),
    .clr     (clr),
    .enq     (len_enq),
    .deq     (len_deq),
    .full_n  (len_full_n),
    .empty_n (len_empty_n),
    .d_in    (len_rec),
    .d_out   (len_rec_out)
  );

  pkt_egress u_egress (
    .CLK           (CLK),
    .arst_n        (arst_n),
    .clr           (clr),
    .len_empty_n   (len_empty_n),
    .len_rec_out   (len_rec_out),
    .len_deq       (len_deq),
    .data_empty_n  (data_empty_n),
    .data_word_out (data_word_out),
    .data_deq      (data_deq),
    .out_empty_n   (out_empty_n),
    .out_word      (out_word),
    .out_deq       (out_deq)
  );

endmodule

`default_nettype wire

//--- testbench/tb_pkt_model.svh
`ifndef TB_PKT_MODEL_SVH
`define TB_PKT_MODEL_SVH

// one packet as it was sent, oldest word first
typedef pkt_pkg::pkt_word_t word_q_t[$];
// egress words expected for one packet, header first
typedef pkt_pkg::pkt_out_t out_q_t[$];

// header word followed by the payload words of one packet
function automatic out_q_t expected_words(input word_q_t pkt, input logic [15:0] seq);
  out_q_t            res;
  pkt_pkg::pkt_hdr_t hdr;
  pkt_pkg::pkt_out_t o;
  int                bytes;
  bytes = 0;
  foreach (pkt[i]) begin
    bytes += int'(pkt[i].nbytes);
  end
  hdr.byte_len = 16'(bytes);
  hdr.word_cnt = 16'(pkt.size());
  hdr.seq      = seq;
  hdr.reserved = '0;
  o.is_hdr     = 1'b1;
  o.body.hdr   = hdr;
  o.nbytes     = 4'd8;
  o.last       = 1'b0;
  res.push_back(o);
  // payload passes unchanged, last marks only the final word
  foreach (pkt[i]) begin
    o.is_hdr   = 1'b0;
    o.body.raw = pkt[i].data;
    o.nbytes   = pkt[i].nbytes;
    o.last     = (i == pkt.size() - 1);
    res.push_back(o);
  end
  return res;
endfunction

task automatic check_out(input string what, input pkt_pkg::pkt_out_t got,
                         input pkt_pkg::pkt_out_t exp);
  if (got !== exp) begin
    abort_run($sformatf({"[ERROR] %0t: %s is_hdr %0b body %h nbytes %0d last %0b,",
                         " expected is_hdr %0b body %h nbytes %0d last %0b"},
                        $time, what, got.is_hdr, got.body.raw, got.nbytes, got.last,
                        exp.is_hdr, exp.body.raw, exp.nbytes, exp.last));
  end
endtask

task automatic check_hdr(input string what, input pkt_pkg::pkt_hdr_t got,
                         input pkt_pkg::pkt_hdr_t exp);
  if (got !== exp) begin
    abort_run($sformatf({"[ERROR] %0t: %s byte_len %0d word_cnt %0d seq %0d rsvd %h,",
                         " expected byte_len %0d word_cnt %0d seq %0d rsvd %h"},
                        $time, what, got.byte_len, got.word_cnt, got.seq, got.reserved,
                        exp.byte_len, exp.word_cnt, exp.seq, exp.reserved));
  end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
  if (got !== exp) begin
    abort_run($sformatf("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp));
  end
endtask

`endif

//--- testbench/tb_pkt_len_prepend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pkt_len_prepend;

  localparam int TIMEOUT     = 2000;
  localparam int SINK_STALL  = 0;
  localparam int SINK_RANDOM = 1;

  logic               CLK;
  logic               arst_n;
  logic               clr;
  logic               in_enq;
  pkt_pkg::pkt_word_t in_word;
  logic               in_full_n;
  logic               out_empty_n;
  logic               out_deq;
  pkt_pkg::pkt_out_t  out_word;

  integer      seed      = 17;
  int          sink_mode = SINK_STALL;
  // cycles left in a random sink pause
  int          hold_cnt  = 0;
  // seq expected in the next header
  logic [15:0] next_seq  = '0;
  logic        saw_full;

  `include "tb_pkt_model.svh"

  // accepted words not yet matched, and words due from the current packet
  word_q_t sent_words;
  out_q_t  exp_q;

  pkt_len_prepend #(
    .data_l2depth (5),
    .len_l2depth  (3)
  ) u_dut (
    .CLK         (CLK),
    .arst_n      (arst_n),
    .clr         (clr),
    .in_enq      (in_enq),
    .in_word     (in_word),
    .in_full_n   (in_full_n),
    .out_empty_n (out_empty_n),
    .out_deq     (out_deq),
    .out_word    (out_word)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on first failure");
  endtask

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // called on a falling edge, returns on a falling edge
  task automatic send_word(input pkt_pkg::pkt_word_t w);
    int waited;
    waited = 0;
    while (!in_full_n) begin
      in_enq = 1'b0;
      @(negedge CLK);
      waited++;
      if (waited > TIMEOUT) abort_run("timeout: in_full_n stayed low");
    end
    in_enq  = 1'b1;
    in_word = w;
    sent_words.push_back(w);
    @(negedge CLK);
    in_enq = 1'b0;
  endtask

  // full words up to the last one, which carries 1 to 8 bytes
  task automatic send_random_packet(input int max_words);
    int                 nwords;
    pkt_pkg::pkt_word_t w;
    nwords = 1 + int'($unsigned($random(seed)) % max_words);
    for (int i = 0; i < nwords; i++) begin
      w.data   = {$random(seed), $random(seed)};
      w.last   = (i == nwords - 1);
      w.nbytes = w.last ? 4'(1 + $unsigned($random(seed)) % 8) : 4'd8;
      send_word(w);
    end
  endtask

  // mode changes on the rising edge, the sink reads it on the falling one
  task automatic set_sink(input int mode);
    @(posedge CLK);
    sink_mode = mode;
    @(negedge CLK);
  endtask

  task automatic watch_full(input int cycles);
    saw_full = 1'b0;
    repeat (cycles) begin
      @(negedge CLK);
      if (!in_full_n) saw_full = 1'b1;
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (sent_words.size() != 0 || exp_q.size() != 0 || out_empty_n) begin
      @(negedge CLK);
      waited++;
      if (waited > TIMEOUT) abort_run("timeout: output did not drain");
    end
  endtask

  // scoreboard step for one word taken from the DUT
  task automatic take_word(input pkt_pkg::pkt_out_t got);
    word_q_t            pkt;
    pkt_pkg::pkt_word_t w;
    pkt_pkg::pkt_out_t  exp;
    if (exp_q.size() == 0) begin
      w = '0;
      while (!w.last && sent_words.size() > 0) begin
        w = sent_words.pop_front();
        pkt.push_back(w);
      end
      if (!w.last) abort_run("output word appeared before a whole packet was sent");
      exp_q = expected_words(pkt, next_seq);
      next_seq++;
    end
    exp = exp_q.pop_front();
    if (exp.is_hdr) check_hdr("header", got.body.hdr, exp.body.hdr);
    check_out("output word", got, exp);
  endtask

  // randomly pausing sink that samples each word at the falling edge
  initial begin
    out_deq = 1'b0;
    forever begin
      @(negedge CLK);
      out_deq = 1'b0;
      if (sink_mode == SINK_RANDOM) begin
        if (hold_cnt > 0) begin
          hold_cnt--;
        end else if ($unsigned($random(seed)) % 16 == 0) begin
          hold_cnt = 1 + int'($unsigned($random(seed)) % 24);
        end else if (out_empty_n) begin
          out_deq = 1'b1;
          take_word(out_word);
        end
      end
    end
  end

  initial begin
    arst_n  = 1'b0;
    clr     = 1'b0;
    in_enq  = 1'b0;
    in_word = '0;
    repeat (8) @(posedge CLK);
    @(negedge CLK);
    arst_n = 1'b1;
    @(negedge CLK);
    check_flag("out_empty_n after reset", out_empty_n, 1'b0);
    check_flag("in_full_n after reset", in_full_n, 1'b1);

    // mixed traffic with a randomly pausing sink
    set_sink(SINK_RANDOM);
    repeat (30) send_random_packet(16);
    wait_drain();

    // long stall fills the data FIFO
    set_sink(SINK_STALL);
    fork
      repeat (12) send_random_packet(16);
      begin
        watch_full(200);
        set_sink(SINK_RANDOM);
      end
    join
    check_flag("in_full_n fell during long stall", saw_full, 1'b1);
    wait_drain();

    // one-word packets fill the length FIFO first
    set_sink(SINK_STALL);
    fork
      repeat (12) send_random_packet(1);
      begin
        watch_full(100);
        set_sink(SINK_RANDOM);
      end
    join
    check_flag("in_full_n fell on short packet burst", saw_full, 1'b1);
    wait_drain();

    // clear with packets buffered and the sink stalled
    set_sink(SINK_STALL);
    repeat (3) send_random_packet(4);
    repeat (6) @(negedge CLK);
    clr = 1'b1;
    @(negedge CLK);
    clr = 1'b0;
    sent_words.delete();
    exp_q.delete();
    next_seq = '0;
    set_sink(SINK_RANDOM);
    repeat (20) begin
      @(negedge CLK);
      check_flag("out_empty_n after clear", out_empty_n, 1'b0);
    end
    repeat (8) send_random_packet(16);
    wait_drain();

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+testbench
hdl/pkt_pkg.sv
hdl/srl_fifo_d.sv
hdl/pkt_ingress.sv
hdl/pkt_egress.sv
hdl/pkt_len_prepend.sv
testbench/tb_pkt_len_prepend.sv

//--- Bender.yml
package:
  name: pkt_len_prepend

sources:
  # synthesizable design, package first
  - files:
      - hdl/pkt_pkg.sv
      - hdl/srl_fifo_d.sv
      - hdl/pkt_ingress.sv
      - hdl/pkt_egress.sv
      - hdl/pkt_len_prepend.sv

  # testbench with its model header
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_pkt_len_prepend.sv
